//--- common/port_sel_pkg.sv
package port_sel_pkg;

    // candidate output ports per transaction
    localparam int num_ports = 4;

    // one occupancy bit per buffer slot
    localparam int mask_w = 15;

    // enough for 0..15 set bits
    localparam int cnt_w = 4;

    // binary port number
    localparam int idx_w = 2;

    typedef logic [mask_w-1:0] mask_t;

    typedef logic [cnt_w-1:0] cnt_t;

    typedef logic [idx_w-1:0] idx_t;

    typedef logic [num_ports-1:0] onehot_t;

    // port 0 sits in the low nibble
    typedef logic [num_ports-1:0][cnt_w-1:0] count_vec_t;

    // winner as one-hot, then index, then its count (10 bits)
    typedef struct packed {
        onehot_t onehot;
        idx_t    index;
        cnt_t    count;
    } result_t;

endpackage

//--- popcount/carry_sum_gen.sv
module carry_sum_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    // low group of four, high group of three
    logic [3:0] grp_lo;
    logic [2:0] grp_hi;

    // per-group ones count
    logic [2:0] j1;
    logic [1:0] j2;

    logic a;
    logic b;
    logic c;

    assign {grp_hi, grp_lo} = in;

    assign j1 = {2'b00, grp_lo[0]} + {2'b00, grp_lo[1]}
              + {2'b00, grp_lo[2]} + {2'b00, grp_lo[3]};
    assign j2 = {1'b0, grp_hi[0]} + {1'b0, grp_hi[1]} + {1'b0, grp_hi[2]};

    // parity of the whole input
    assign s = j1[0] ^ j2[0];

    // low group holds at least one pair
    assign a = (j1 > 3'd1);

    // high group holds at least one pair
    assign b = (j2 > 2'd1);

    // second pair of a full low group, or the pair formed by two odd leftovers
    assign c = (j1 == 3'd4) | (j1[0] & j2[0]);

    assign abc = {a, b, c};

    // every abc bit stands for two ones, s for the leftover one
    cs_weight_chk: assert final (
        $isunknown(in) ||
        $countones(in) == int'(s) + 2 * (int'(abc[2]) + int'(abc[1]) + int'(abc[0]))
    ) else $error("carry_sum_gen weight mismatch in=%b abc=%b s=%b", in, abc, s);

endmodule

//--- popcount/popcount_15.sv
module popcount_15 (
    input  port_sel_pkg::mask_t in,
    output port_sel_pkg::cnt_t  count
);

    // weight-two bits of the two first-level cells
    logic [2:0] abc_lo;
    logic [2:0] abc_hi;

    // weight-two bits of the (7,3) stage
    logic [2:0] abc_top;

    // first-level parities
    logic s_lo;
    logic s_hi;

    // carry out of the weight-one sum
    logic carry_0;

    // bits 0..6
    carry_sum_gen cs_lo_i (
        .in  (in[6:0]),
        .abc (abc_lo),
        .s   (s_lo)
    );

    // bits 7..13
    carry_sum_gen cs_hi_i (
        .in  (in[13:7]),
        .abc (abc_hi),
        .s   (s_hi)
    );

    // bit 14 joins the two parities
    // low count bit plus one more weight-two bit
    assign {carry_0, count[0]} = {1'b0, in[14]} + {1'b0, s_lo} + {1'b0, s_hi};

    // (7,3) stage over the seven weight-two bits
    carry_sum_gen cs_top_i (
        .in  ({abc_lo, abc_hi, carry_0}),
        .abc (abc_top),
        .s   (count[1])
    );

    // at most three weight-four bits, fits in two
    assign count[3:2] = {1'b0, abc_top[0]} + {1'b0, abc_top[1]} + {1'b0, abc_top[2]};

endmodule

//--- design/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // room when empty or draining this cycle
    assign in_ready = !valid_q || out_ready;

    // occupancy flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only loads on a real transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // a stalled stage keeps its word
    hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pipe_reg lost or changed data while stalled");

endmodule

//--- design/min_select.sv
module min_select (
    input  port_sel_pkg::count_vec_t counts,
    output port_sel_pkg::result_t    result
);

    // comp[i][j] says port i beats the j-th other port
    logic [port_sel_pkg::num_ports-2:0] comp [port_sel_pkg::num_ports];

    port_sel_pkg::onehot_t winner;

    // index and count of each port, zeroed unless it wins
    logic [port_sel_pkg::idx_w+port_sel_pkg::cnt_w-1:0] entry [port_sel_pkg::num_ports];

    // masked-OR of all entries
    logic [port_sel_pkg::idx_w+port_sel_pkg::cnt_w-1:0] picked;

    for (genvar i = 0; i < port_sel_pkg::num_ports; i++) begin : g_row
        for (genvar j = 0; j < port_sel_pkg::num_ports - 1; j++) begin : g_col
            if (i > j) begin : g_lower
                // reuse the mirrored compare, strict so the lower port keeps ties
                assign comp[i][j] = ~comp[j][i-1];
            end else begin : g_upper
                // against port j+1, ties go to i
                assign comp[i][j] = (counts[i] <= counts[j+1]);
            end
        end

        assign winner[i] = &comp[i];

        // index constant next to its count
        assign entry[i] = {port_sel_pkg::idx_t'(i), counts[i]}
                        & {(port_sel_pkg::idx_w + port_sel_pkg::cnt_w){winner[i]}};
    end

    // one-hot mux, exactly one entry survives
    always_comb begin
        picked = '0;
        for (int k = 0; k < port_sel_pkg::num_ports; k++) begin
            picked = picked | entry[k];
        end
    end

    assign result.onehot = winner;
    assign result.index  = picked[port_sel_pkg::idx_w+port_sel_pkg::cnt_w-1:port_sel_pkg::cnt_w];
    assign result.count  = picked[port_sel_pkg::cnt_w-1:0];

    // counts stay unknown until the first stage has loaded once
    winner_onehot: assert final ($isunknown(counts) || $onehot(winner))
        else $error("min_select winner not one-hot: %b", winner);

endmodule

//--- design/least_loaded_select.sv
module least_loaded_select (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  port_sel_pkg::mask_t   in_mask_0,
    input  port_sel_pkg::mask_t   in_mask_1,
    input  port_sel_pkg::mask_t   in_mask_2,
    input  port_sel_pkg::mask_t   in_mask_3,

    output logic                  out_valid,
    input  logic                  out_ready,
    output port_sel_pkg::onehot_t out_onehot,
    output port_sel_pkg::idx_t    out_index,
    output port_sel_pkg::cnt_t    out_count
);

    port_sel_pkg::mask_t masks [port_sel_pkg::num_ports];

    // popcounts straight from the input masks
    port_sel_pkg::count_vec_t counts_d;

    // first stage output
    port_sel_pkg::count_vec_t counts_q;
    logic                     mid_valid;
    logic                     mid_ready;

    // selector result before and after the second stage
    port_sel_pkg::result_t    result_d;
    port_sel_pkg::result_t    result_q;

    assign masks[0] = in_mask_0;
    assign masks[1] = in_mask_1;
    assign masks[2] = in_mask_2;
    assign masks[3] = in_mask_3;

    // one (15,4) counter per candidate port
    for (genvar p = 0; p < port_sel_pkg::num_ports; p++) begin : g_count
        popcount_15 popcount_i (
            .in    (masks[p]),
            .count (counts_d[p])
        );
    end

    // stage 1 holds the counts
    pipe_reg #(
        .payload_t (port_sel_pkg::count_vec_t)
    ) count_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (counts_d),
        .out_valid (mid_valid),
        .out_ready (mid_ready),
        .out_data  (counts_q)
    );

    // least loaded port, lowest index on ties
    min_select min_select_i (
        .counts (counts_q),
        .result (result_d)
    );

    // stage 2 holds the winner
    pipe_reg #(
        .payload_t (port_sel_pkg::result_t)
    ) result_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mid_valid),
        .in_ready  (mid_ready),
        .in_data   (result_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (result_q)
    );

    assign out_onehot = result_q.onehot;
    assign out_index  = result_q.index;
    assign out_count  = result_q.count;

endmodule

//--- tests/tb_least_loaded_select.sv
module tb_least_loaded_select;

    // clock and run limits
    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int max_pat      = 64;
    localparam int wd_cycles    = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    port_sel_pkg::mask_t   in_mask_0;
    port_sel_pkg::mask_t   in_mask_1;
    port_sel_pkg::mask_t   in_mask_2;
    port_sel_pkg::mask_t   in_mask_3;
    logic                  out_valid;
    logic                  out_ready;
    port_sel_pkg::onehot_t out_onehot;
    port_sel_pkg::idx_t    out_index;
    port_sel_pkg::cnt_t    out_count;

    // pattern table loaded from the data file
    port_sel_pkg::mask_t pat_mask [max_pat][port_sel_pkg::num_ports];
    port_sel_pkg::idx_t  pat_idx [max_pat];
    port_sel_pkg::cnt_t  pat_cnt [max_pat];
    int                  num_pat;
    logic                load_done;

    // expected values travel next to the driven masks
    port_sel_pkg::idx_t drv_idx;
    port_sel_pkg::cnt_t drv_cnt;
    int                 drv_id;

    // scoreboard with the oldest accepted transaction at the front
    port_sel_pkg::idx_t exp_idx_q [$];
    port_sel_pkg::cnt_t exp_cnt_q [$];
    int                 exp_id_q [$];
    longint             acc_cycle_q [$];

    longint cycle;
    int     rcv_count;
    int     err_count;
    int     tests_run;
    int     tests_failed;

    // enables for random out_ready and for the latency check
    logic bp_mode;
    logic check_latency;

    least_loaded_select dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_mask_0  (in_mask_0),
        .in_mask_1  (in_mask_1),
        .in_mask_2  (in_mask_2),
        .in_mask_3  (in_mask_3),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_onehot (out_onehot),
        .out_index  (out_index),
        .out_count  (out_count)
    );

    always #(clk_period / 2) clk = ~clk;

    // expected one-hot code for a port index
    function automatic port_sel_pkg::onehot_t onehot_of(input port_sel_pkg::idx_t idx);
        onehot_of      = '0;
        onehot_of[idx] = 1'b1;
    endfunction

    // sink stalls about half the cycles in back-pressure mode
    always @(posedge clk) begin
        if (bp_mode) begin
            out_ready <= (($urandom % 100) < 50);
        end else begin
            out_ready <= 1'b1;
        end
    end

    // watches both handshakes and scores every output transfer
    always @(posedge clk) begin : monitor
        port_sel_pkg::idx_t e_idx;
        port_sel_pkg::cnt_t e_cnt;
        int                 e_id;
        longint             e_cycle;
        cycle = cycle + 1;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                exp_idx_q.push_back(drv_idx);
                exp_cnt_q.push_back(drv_cnt);
                exp_id_q.push_back(drv_id);
                acc_cycle_q.push_back(cycle);
            end
            if (out_valid && out_ready) begin
                if (exp_idx_q.size() == 0) begin
                    $display("error at %0t: output transfer with nothing pending", $time);
                    err_count++;
                end else begin
                    e_idx   = exp_idx_q.pop_front();
                    e_cnt   = exp_cnt_q.pop_front();
                    e_id    = exp_id_q.pop_front();
                    e_cycle = acc_cycle_q.pop_front();
                    if (out_index !== e_idx) begin
                        $display("mismatch at %0t: pattern %0d index %0d, expected %0d",
                                 $time, e_id, out_index, e_idx);
                        err_count++;
                    end
                    if (out_count !== e_cnt) begin
                        $display("mismatch at %0t: pattern %0d count %0d, expected %0d",
                                 $time, e_id, out_count, e_cnt);
                        err_count++;
                    end
                    if (out_onehot !== onehot_of(e_idx)) begin
                        $display("mismatch at %0t: pattern %0d one-hot %b, expected %b",
                                 $time, e_id, out_onehot, onehot_of(e_idx));
                        err_count++;
                    end
                    // two register stages between the handshakes
                    if (check_latency && (cycle - e_cycle != 2)) begin
                        $display("mismatch at %0t: pattern %0d latency %0d cycles, expected 2",
                                 $time, e_id, cycle - e_cycle);
                        err_count++;
                    end
                end
                rcv_count++;
            end
            // in_ready may only drop behind a stalled output
            if (!in_ready && !(out_valid && !out_ready)) begin
                $display("mismatch at %0t: in_ready low while the output is not stalled",
                         $time);
                err_count++;
            end
        end
    end

    // reads the pattern file, skipping comment and blank lines
    task automatic load_patterns;
        int          fd;
        int          fields;
        string       line;
        logic [31:0] m0;
        logic [31:0] m1;
        logic [31:0] m2;
        logic [31:0] m3;
        logic [31:0] ix;
        logic [31:0] ct;
        num_pat = 0;
        fd = $fopen("tests/least_loaded_patterns.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open tests/least_loaded_patterns.txt");
            err_count++;
        end else begin
            while (!$feof(fd) && num_pat < max_pat) begin
                line   = "";
                fields = $fgets(line, fd);
                if (fields > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h", m0, m1, m2, m3, ix, ct);
                    if (fields == 6) begin
                        pat_mask[num_pat][0] = m0[port_sel_pkg::mask_w-1:0];
                        pat_mask[num_pat][1] = m1[port_sel_pkg::mask_w-1:0];
                        pat_mask[num_pat][2] = m2[port_sel_pkg::mask_w-1:0];
                        pat_mask[num_pat][3] = m3[port_sel_pkg::mask_w-1:0];
                        pat_idx[num_pat]     = ix[port_sel_pkg::idx_w-1:0];
                        pat_cnt[num_pat]     = ct[port_sel_pkg::cnt_w-1:0];
                        num_pat++;
                    end else if (fields > 0) begin
                        $display("error: malformed pattern line: %s", line);
                        err_count++;
                    end
                end
            end
            $fclose(fd);
            if (num_pat == 0) begin
                $display("error: no patterns found in tests/least_loaded_patterns.txt");
                err_count++;
            end
        end
    endtask

    // pushes every pattern through, then waits for the pipeline to drain
    task automatic run_patterns;
        int start_rcv;
        start_rcv = rcv_count;
        for (int i = 0; i < num_pat; i++) begin
            in_valid  <= 1'b1;
            in_mask_0 <= pat_mask[i][0];
            in_mask_1 <= pat_mask[i][1];
            in_mask_2 <= pat_mask[i][2];
            in_mask_3 <= pat_mask[i][3];
            drv_idx   <= pat_idx[i];
            drv_cnt   <= pat_cnt[i];
            drv_id    <= i;
            // masks stay put until the DUT takes them
            do begin
                @(posedge clk);
            end while (!in_ready);
        end
        in_valid <= 1'b0;
        while (rcv_count - start_rcv < num_pat) begin
            @(posedge clk);
        end
        // idle tail catches any extra output
        repeat (4) @(posedge clk);
        if (rcv_count - start_rcv != num_pat) begin
            $display("mismatch at %0t: %0d results received, expected %0d",
                     $time, rcv_count - start_rcv, num_pat);
            err_count++;
        end
        if (exp_idx_q.size() != 0) begin
            $display("error: %0d accepted transactions never produced a result",
                     exp_idx_q.size());
            err_count++;
        end
        if (out_valid !== 1'b0) begin
            $display("mismatch at %0t: out_valid still high after the drain", $time);
            err_count++;
        end
    endtask

    // one line per finished test
    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (err_count != err_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - err_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    initial begin : main
        int t_err;
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_mask_0     = '0;
        in_mask_1     = '0;
        in_mask_2     = '0;
        in_mask_3     = '0;
        out_ready     = 1'b1;
        drv_idx       = '0;
        drv_cnt       = '0;
        drv_id        = 0;
        bp_mode       = 1'b0;
        check_latency = 1'b0;
        cycle         = 0;
        rcv_count     = 0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        load_done     = 1'b0;
        void'($urandom(32'h7df2));
        load_patterns();
        load_done = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // empty pipeline right after reset
        t_err = err_count;
        if (out_valid !== 1'b0) begin
            $display("mismatch at %0t: out_valid is %b after reset, expected 0", $time, out_valid);
            err_count++;
        end
        if (in_ready !== 1'b1) begin
            $display("mismatch at %0t: in_ready is %b after reset, expected 1", $time, in_ready);
            err_count++;
        end
        report_test("reset", t_err);

        if (num_pat > 0) begin
            // file holds ties, single minimum per port and mixed masks
            t_err = err_count;
            check_latency <= 1'b1;
            run_patterns();
            report_test("counting and selection", t_err);

            // same patterns again with a stalling sink
            t_err = err_count;
            check_latency <= 1'b0;
            bp_mode       <= 1'b1;
            run_patterns();
            bp_mode <= 1'b0;
            report_test("back-pressure", t_err);
        end

        $display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, rcv_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // two passes over the file, ten cycles per pattern, plus reset and slack
    initial begin : watchdog
        longint limit;
        wait (load_done === 1'b1);
        limit = longint'(num_pat) * 2 * wd_cycles * clk_period
              + (reset_cycles + 20) * clk_period;
        #(limit);
        $display("error: run timed out at %0t with results still pending", $time);
        $display("Something failed");
        $finish;
    end

endmodule

//--- compile.f
common/port_sel_pkg.sv
popcount/carry_sum_gen.sv
popcount/popcount_15.sv
design/pipe_reg.sv
design/min_select.sv
design/least_loaded_select.sv
tests/tb_least_loaded_select.sv

//--- run.sh
#!/bin/sh
# build and run the least-loaded selector testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_least_loaded_select -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Everything OK" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- tests/least_loaded_patterns.txt
# columns: mask0 mask1 mask2 mask3 expected_index expected_count, all hex
# masks are 15 bits with port 0 first, equal minimum counts pick the lowest port
0000 0000 0000 0000 0 0
7fff 7fff 7fff 7fff 0 f
0001 4000 0100 0010 0 1
00ff 0f0f 5555 3333 0 8
7fff 0003 4001 0101 1 2
7fff 7fff 000f 1111 2 4
03ff 0007 7000 0842 1 3
1fff 1fff 1fff 0fff 3 c
0ff0 5a5a 0003 0101 2 2
3fff 7ffe 3fff 7bde 3 c
0000 7fff 0000 7fff 0 0
7fff 0000 7fff 0000 1 0
0000 7fff 7fff 7fff 0 0
7fff 0000 7fff 7fff 1 0
7fff 7fff 0000 7fff 2 0
7fff 7fff 7fff 0000 3 0
0001 0003 0007 000f 0 1
0003 0001 0007 000f 1 1
000f 0007 0001 0003 2 1
0007 000f 0003 0001 3 1
7ffe 7fff 7fff 7fff 0 e
7fff 7ffe 7fff 7fff 1 e
7fff 7fff 7ffe 7fff 2 e
7fff 7fff 7fff 7ffe 3 e
1fff 01ff 3fff 07ff 1 9
00ff 03ff 001f 0fff 2 5
3333 6666 5555 2aaa 3 7
4000 0000 2000 1000 1 0
2468 1357 7531 1248 3 4
6db6 7f00 00aa 0ff0 2 4
0c30 01c0 0380 7e00 1 3
5a5a 3c3c 0842 0101 3 2
00f0 1248 0c30 1111 0 4
7f00 00ff 7e00 01c0 3 3
4001 0842 2468 7000 0 2
7bde 6db6 1fff 3fff 1 a
0fff 0ff0 0f0f 00ff 1 8
7531 2aaa 1357 6666 1 7
0380 4000 0001 7fff 1 1
07ff 03ff 01ff 00ff 3 8
3c3c 0c30 00aa 0003 3 2
4000 0380 01c0 0000 3 0
0003 0842 6db6 7bde 0 2
5b2d 19c7 0e13 63a9 2 6
7e81 4a70 2c4f 35d1 1 6
0e13 4a70 5b2d 7e81 0 6
